// ==== verilog/iw_defines.svh ====
`ifndef IW_DEFINES_SVH
`define IW_DEFINES_SVH

// number of slots in the window
`define IW_DEPTH 8

// oldest slots allowed to issue
`define IW_ISSUE_RANGE 4

// virtual register tag
`define IW_TAG_W 6

// operand word
`define IW_WORD_W 32

// one-hot branch context
`define IW_CTX_W 4

// opcode handed to execute
`define IW_OP_W 4

`endif

// ==== verilog/iw_pkg.sv ====
`default_nettype none

`include "iw_defines.svh"

package iw_pkg;

    typedef logic [`IW_TAG_W-1:0]          tag_t;
    typedef logic [`IW_WORD_W-1:0]         word_t;
    typedef logic [`IW_CTX_W-1:0]          ctx_t;
    typedef logic [`IW_OP_W-1:0]           op_t;
    typedef logic [$clog2(`IW_DEPTH)-1:0]  slot_t;
    typedef logic [`IW_DEPTH-1:0]          slot_vec_t;

    // one decoded instruction from dispatch
    typedef struct packed {
        op_t   op;
        ctx_t  ctx;
        tag_t  dest;
        logic  src1_ready;
        tag_t  src1_tag;
        word_t src1_val;
        logic  src2_ready;
        tag_t  src2_tag;
        word_t src2_val;
        logic  use_imm;
        word_t imm;
    } dispatch_t;

    // result broadcast
    typedef struct packed {
        tag_t  tag;
        word_t value;
    } result_t;

    typedef struct packed {
        op_t   op;
        ctx_t  ctx;
        tag_t  dest;
        logic  src1_ready;
        tag_t  src1_tag;
        word_t src1_val;
        logic  src2_ready;
        tag_t  src2_tag;
        word_t src2_val;
    } entry_t;

    // what execute needs, operands already resolved
    typedef struct packed {
        op_t   op;
        ctx_t  ctx;
        tag_t  dest;
        word_t src1_val;
        word_t src2_val;
    } issue_t;

endpackage

`default_nettype wire

// ==== verilog/window_compact.sv ====
`default_nettype none

`include "iw_defines.svh"

module window_compact (
    input  iw_pkg::slot_vec_t keep_vec,
    output iw_pkg::slot_t     move_src [`IW_DEPTH],
    output iw_pkg::slot_vec_t move_valid
);
    import iw_pkg::*;

    // reach[k][j] set once slots 0..j hold at least k+1 kept entries
    slot_vec_t reach [`IW_DEPTH];
    // first j where reach[k] turns on, one-hot
    slot_vec_t pick  [`IW_DEPTH];

    // prefix table over the kept slots
    always_comb begin
        reach[0][0] = keep_vec[0];
        for (int j = 1; j < `IW_DEPTH; j++) begin
            reach[0][j] = reach[0][j-1] || keep_vec[j];
        end
        for (int k = 1; k < `IW_DEPTH; k++) begin
            reach[k][0] = 1'b0;
            for (int j = 1; j < `IW_DEPTH; j++) begin
                reach[k][j] = reach[k][j-1] || (reach[k-1][j-1] && keep_vec[j]);
            end
        end
    end

    // slot k takes the (k+1)-th kept old slot
    always_comb begin
        for (int k = 0; k < `IW_DEPTH; k++) begin
            pick[k]       = reach[k] & ~(reach[k] << 1);
            move_valid[k] = reach[k][`IW_DEPTH-1];
            move_src[k]   = '0;
            for (int j = 0; j < `IW_DEPTH; j++) begin
                if (pick[k][j]) begin
                    move_src[k] = move_src[k] | slot_t'(j);
                end
            end
        end
    end

    // age order kept and no holes below a filled slot
    always_comb begin
        for (int k = 1; k < `IW_DEPTH; k++) begin
            if (move_valid[k]) begin
                a_move_order: assert (move_valid[k-1] && move_src[k] > move_src[k-1]);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/issue_select.sv ====
`default_nettype none

`include "iw_defines.svh"

module issue_select (
    input  logic              clk,
    input  logic              rst,
    input  iw_pkg::slot_vec_t entry_valid,
    input  iw_pkg::entry_t    entries [`IW_DEPTH],
    output logic              exec_valid,
    input  logic              exec_ready,
    output iw_pkg::issue_t    exec_info,
    output iw_pkg::slot_vec_t issued_vec
);
    import iw_pkg::*;

    logic [`IW_ISSUE_RANGE-1:0] ready_vec;
    slot_t                      sel_slot;
    issue_t                     held_q;
    logic                       held_hit;
    slot_t                      held_pos;

    function automatic issue_t to_issue(entry_t e);
        issue_t p;
        p.op       = e.op;
        p.ctx      = e.ctx;
        p.dest     = e.dest;
        p.src1_val = e.src1_val;
        p.src2_val = e.src2_val;
        return p;
    endfunction

    // only the oldest slots may go to execute
    always_comb begin
        for (int i = 0; i < `IW_ISSUE_RANGE; i++) begin
            ready_vec[i] = entry_valid[i] && entries[i].src1_ready && entries[i].src2_ready;
        end
    end

    // lowest slot wins, slot 0 is oldest
    always_comb begin
        exec_valid = 1'b0;
        sel_slot   = '0;
        for (int i = `IW_ISSUE_RANGE - 1; i >= 0; i--) begin
            if (ready_vec[i]) begin
                exec_valid = 1'b1;
                sel_slot   = slot_t'(i);
            end
        end
    end

    assign exec_info  = to_issue(entries[sel_slot]);
    assign issued_vec = (exec_valid && exec_ready) ? (slot_vec_t'(1) << sel_slot) : '0;

    // where last cycle's offer sits now, if it survived compaction
    always_ff @(posedge clk) begin
        held_q <= exec_info;
    end

    always_comb begin
        held_hit = 1'b0;
        held_pos = '0;
        for (int i = `IW_DEPTH - 1; i >= 0; i--) begin
            if (entry_valid[i] && to_issue(entries[i]) == held_q) begin
                held_hit = 1'b1;
                held_pos = slot_t'(i);
            end
        end
    end

    // a stalled offer is held until taken, only an older wakeup may jump ahead
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        exec_valid && !exec_ready |=>
            !held_hit || (exec_valid && (exec_info == held_q || sel_slot < held_pos)));

endmodule

`default_nettype wire

// ==== verilog/window_entries.sv ====
`default_nettype none

`include "iw_defines.svh"

module window_entries (
    input  logic              clk,
    input  logic              rst,

    input  logic              dispatch_valid,
    output logic              dispatch_ready,
    input  iw_pkg::dispatch_t dispatch_info,

    input  logic              result_valid,
    input  iw_pkg::result_t   result,

    input  logic              branch_hazard,
    input  iw_pkg::ctx_t      hazard_ctx,

    // from issue select and compactor
    input  iw_pkg::slot_vec_t issued_vec,
    input  iw_pkg::slot_t     move_src [`IW_DEPTH],
    input  iw_pkg::slot_vec_t move_valid,

    output iw_pkg::slot_vec_t keep_vec,
    output iw_pkg::slot_vec_t entry_valid,
    output iw_pkg::entry_t    entries [`IW_DEPTH]
);
    import iw_pkg::*;

    localparam int CNT_W = $clog2(`IW_DEPTH + 1);

    entry_t           entry_q [`IW_DEPTH];
    slot_vec_t        valid_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] kept_cnt;
    slot_vec_t        kill_vec;
    slot_t            append_slot;
    entry_t           new_entry;
    logic             accept;

    // capture a broadcast result into any waiting operand with that tag
    function automatic entry_t wake(entry_t e, logic hit, result_t r);
        entry_t w;
        w = e;
        if (hit && !e.src1_ready && e.src1_tag == r.tag) begin
            w.src1_ready = 1'b1;
            w.src1_val   = r.value;
        end
        if (hit && !e.src2_ready && e.src2_tag == r.tag) begin
            w.src2_ready = 1'b1;
            w.src2_val   = r.value;
        end
        return w;
    endfunction

    // incoming instruction, immediate makes source 2 ready at once
    always_comb begin : build_dispatch
        entry_t raw;
        raw.op         = dispatch_info.op;
        raw.ctx        = dispatch_info.ctx;
        raw.dest       = dispatch_info.dest;
        raw.src1_ready = dispatch_info.src1_ready;
        raw.src1_tag   = dispatch_info.src1_tag;
        raw.src1_val   = dispatch_info.src1_val;
        raw.src2_ready = dispatch_info.src2_ready || dispatch_info.use_imm;
        raw.src2_tag   = dispatch_info.src2_tag;
        raw.src2_val   = dispatch_info.use_imm ? dispatch_info.imm : dispatch_info.src2_val;
        new_entry      = wake(raw, result_valid, result);
    end

    // hazard kills entries on an overlapping path
    always_comb begin
        for (int i = 0; i < `IW_DEPTH; i++) begin
            kill_vec[i] = branch_hazard && (entry_q[i].ctx & hazard_ctx) != '0;
        end
    end

    // an entry issued in the hazard cycle leaves as issued
    assign keep_vec       = valid_q & ~issued_vec & ~kill_vec;
    assign kept_cnt       = CNT_W'($countones(keep_vec));
    assign append_slot    = slot_t'(kept_cnt);
    assign dispatch_ready = count_q < CNT_W'(`IW_DEPTH);
    assign accept         = dispatch_valid && dispatch_ready;

    assign entry_valid = valid_q;
    assign entries     = entry_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            count_q <= '0;
        end else begin
            valid_q <= move_valid;
            if (accept) begin
                valid_q[append_slot] <= 1'b1;
            end
            count_q <= kept_cnt + CNT_W'(accept);
        end
    end

    // compacted slots first, new instruction right behind them
    always_ff @(posedge clk) begin
        for (int k = 0; k < `IW_DEPTH; k++) begin
            if (move_valid[k]) begin
                entry_q[k] <= wake(entry_q[move_src[k]], result_valid, result);
            end else if (accept && append_slot == slot_t'(k)) begin
                entry_q[k] <= new_entry;
            end
        end
    end

    // count matches the valid slots and stays within the window
    a_occupancy: assert property (@(posedge clk) disable iff (rst)
        count_q <= CNT_W'(`IW_DEPTH) && count_q == CNT_W'($countones(valid_q)));

    // a full window adds nothing on this edge
    a_full_no_dispatch: assert property (@(posedge clk) disable iff (rst)
        count_q == CNT_W'(`IW_DEPTH) |=> count_q == $past(kept_cnt));

    a_reset_empty: assert property (@(posedge clk)
        rst |=> entry_valid == '0);

endmodule

`default_nettype wire

// ==== verilog/inst_window.sv ====
`default_nettype none

`include "iw_defines.svh"

module inst_window (
    input  logic              clk,
    input  logic              rst,

    // from dispatch
    input  logic              dispatch_valid,
    output logic              dispatch_ready,
    input  iw_pkg::dispatch_t dispatch_info,

    // result broadcast
    input  logic              result_valid,
    input  iw_pkg::result_t   result,

    // branch hazard
    input  logic              branch_hazard,
    input  iw_pkg::ctx_t      hazard_ctx,

    // to execute
    output logic              exec_valid,
    input  logic              exec_ready,
    output iw_pkg::issue_t    exec_info
);
    import iw_pkg::*;

    slot_vec_t entry_valid;
    entry_t    entries [`IW_DEPTH];
    slot_vec_t keep_vec;
    slot_t     move_src [`IW_DEPTH];
    slot_vec_t move_valid;
    // one-hot, set only on a completed issue handshake
    slot_vec_t issued_slot_vec;

    window_entries u_entries (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_info  (dispatch_info),
        .result_valid   (result_valid),
        .result         (result),
        .branch_hazard  (branch_hazard),
        .hazard_ctx     (hazard_ctx),
        .issued_vec     (issued_slot_vec),
        .move_src       (move_src),
        .move_valid     (move_valid),
        .keep_vec       (keep_vec),
        .entry_valid    (entry_valid),
        .entries        (entries)
    );

    // which old slot lands in each slot after removals
    window_compact u_compact (
        .keep_vec   (keep_vec),
        .move_src   (move_src),
        .move_valid (move_valid)
    );

    issue_select u_select (
        .clk         (clk),
        .rst         (rst),
        .entry_valid (entry_valid),
        .entries     (entries),
        .exec_valid  (exec_valid),
        .exec_ready  (exec_ready),
        .exec_info   (exec_info),
        .issued_vec  (issued_slot_vec)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_iw_checks.sv ====
`default_nettype none

`include "iw_defines.svh"

module tb_iw_checks (
    input logic              clk,
    input logic              rst,
    input logic              dispatch_valid,
    input logic              dispatch_ready,
    input iw_pkg::dispatch_t dispatch_info,
    input logic              result_valid,
    input iw_pkg::result_t   result,
    input logic              branch_hazard,
    input iw_pkg::ctx_t      hazard_ctx,
    input logic              exec_valid,
    input logic              exec_ready,
    input iw_pkg::issue_t    exec_info
);
    timeunit 1ns;
    timeprecision 1ps;
    import iw_pkg::*;

    string  test_name   = "none";
    int     err_count   = 0;
    int     issue_count = 0;
    int     model_count = 0;
    // expected window contents, oldest first
    entry_t model_q [$];
    logic   exp_valid   = 1'b0;
    issue_t exp_info    = '0;
    int     exp_idx     = 0;

    function automatic entry_t capture_result(entry_t e, logic hit, result_t r);
        entry_t n;
        n = e;
        if (hit && !n.src1_ready && n.src1_tag == r.tag) begin
            n.src1_ready = 1'b1;
            n.src1_val   = r.value;
        end
        if (hit && !n.src2_ready && n.src2_tag == r.tag) begin
            n.src2_ready = 1'b1;
            n.src2_val   = r.value;
        end
        return n;
    endfunction

    // immediate replaces source 2 and is ready at once
    function automatic entry_t admit(dispatch_t d);
        entry_t e;
        e.op         = d.op;
        e.ctx        = d.ctx;
        e.dest       = d.dest;
        e.src1_ready = d.src1_ready;
        e.src1_tag   = d.src1_tag;
        e.src1_val   = d.src1_val;
        e.src2_ready = d.src2_ready || d.use_imm;
        e.src2_tag   = d.src2_tag;
        e.src2_val   = d.use_imm ? d.imm : d.src2_val;
        return e;
    endfunction

    // retire, kill, wake, then append, all on the same edge
    always @(posedge clk) begin
        int n_before;
        n_before = model_q.size();
        if (rst) begin
            model_q.delete();
        end else begin
            if (exp_valid && exec_ready) begin
                model_q.delete(exp_idx);
                issue_count++;
            end
            if (branch_hazard) begin
                for (int i = model_q.size() - 1; i >= 0; i--) begin
                    if ((model_q[i].ctx & hazard_ctx) != '0) begin
                        model_q.delete(i);
                    end
                end
            end
            for (int i = 0; i < model_q.size(); i++) begin
                model_q[i] = capture_result(model_q[i], result_valid, result);
            end
            if (dispatch_valid && n_before < `IW_DEPTH) begin
                model_q.push_back(capture_result(admit(dispatch_info), result_valid, result));
            end
        end
        model_count = model_q.size();
        // oldest fully ready entry in the issue range
        exp_valid = 1'b0;
        exp_idx   = 0;
        exp_info  = '0;
        for (int i = model_q.size() - 1; i >= 0; i--) begin
            if (i < `IW_ISSUE_RANGE && model_q[i].src1_ready && model_q[i].src2_ready) begin
                exp_valid         = 1'b1;
                exp_idx           = i;
                exp_info.op       = model_q[i].op;
                exp_info.ctx      = model_q[i].ctx;
                exp_info.dest     = model_q[i].dest;
                exp_info.src1_val = model_q[i].src1_val;
                exp_info.src2_val = model_q[i].src2_val;
            end
        end
    end

    a_after_reset: assert property (@(posedge clk) $fell(rst) |-> !exec_valid && dispatch_ready)
        else begin
            err_count++;
            $display("FAILED %s: valid/ready expected 0/1 actual %b/%b", test_name,
                     $sampled(exec_valid), $sampled(dispatch_ready));
        end

    a_offer: assert property (@(posedge clk) disable iff (rst) exec_valid == exp_valid)
        else begin
            err_count++;
            $display("FAILED %s: exec_valid expected %b actual %b", test_name,
                     $sampled(exp_valid), $sampled(exec_valid));
        end

    a_payload: assert property (@(posedge clk) disable iff (rst)
        exec_valid && exec_ready |-> exec_info == exp_info)
        else begin
            err_count++;
            $display("FAILED %s: exec_info expected %h actual %h", test_name,
                     $sampled(exp_info), $sampled(exec_info));
        end

    a_room: assert property (@(posedge clk) disable iff (rst)
        dispatch_ready == (model_count < `IW_DEPTH))
        else begin
            err_count++;
            $display("FAILED %s: dispatch_ready expected %b actual %b", test_name,
                     $sampled(model_count) < `IW_DEPTH, $sampled(dispatch_ready));
        end

    // nothing can jump ahead without a wakeup or a flush
    a_stall: assert property (@(posedge clk) disable iff (rst)
        exec_valid && !exec_ready && !result_valid && !branch_hazard
            |=> exec_valid && $stable(exec_info))
        else begin
            err_count++;
            $display("%s: stalled issue changed before execute accepted it", test_name);
        end

endmodule

`default_nettype wire

// ==== testbench/tb_inst_window.sv ====
`default_nettype none

`include "iw_defines.svh"

module tb_inst_window;
    timeunit 1ns;
    timeprecision 1ps;
    import iw_pkg::*;

    // cycle budget per test, run limit is their sum plus slack
    localparam int RESET_CYCLES  = 10;
    localparam int READY_CYCLES  = 60;
    localparam int WAKE_CYCLES   = 90;
    localparam int RANGE_CYCLES  = 80;
    localparam int FULL_CYCLES   = 110;
    localparam int HAZARD_CYCLES = 90;
    localparam int CYCLE_LIMIT   = RESET_CYCLES + READY_CYCLES + WAKE_CYCLES
                                   + RANGE_CYCLES + FULL_CYCLES + HAZARD_CYCLES + 160;

    logic      clk;
    logic      rst;
    logic      dispatch_valid;
    logic      dispatch_ready;
    dispatch_t dispatch_info;
    logic      result_valid;
    result_t   result;
    logic      branch_hazard;
    ctx_t      hazard_ctx;
    logic      exec_valid;
    logic      exec_ready;
    issue_t    exec_info;

    int   seed        = 74;
    int   cycles      = 0;
    int   errs_before = 0;
    int   tests_run   = 0;
    logic stall       = 1'b0;
    logic jitter      = 1'b0;
    logic coin        = 1'b1;

    inst_window u_dut (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_info  (dispatch_info),
        .result_valid   (result_valid),
        .result         (result),
        .branch_hazard  (branch_hazard),
        .hazard_ctx     (hazard_ctx),
        .exec_valid     (exec_valid),
        .exec_ready     (exec_ready),
        .exec_info      (exec_info)
    );

    tb_iw_checks u_checks (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_info  (dispatch_info),
        .result_valid   (result_valid),
        .result         (result),
        .branch_hazard  (branch_hazard),
        .hazard_ctx     (hazard_ctx),
        .exec_valid     (exec_valid),
        .exec_ready     (exec_ready),
        .exec_info      (exec_info)
    );

    always #5 clk = ~clk;

    // random back-pressure, so issue latency varies
    always @(negedge clk) begin
        coin <= ($random(seed) % 3) != 0;
    end

    assign exec_ready = !stall && (!jitter || coin);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the window did not drain", cycles);
            $display("Errors found");
            $finish;
        end
    end

    function automatic dispatch_t make_inst(op_t op, ctx_t ctx, logic r1, tag_t t1,
                                            logic r2, tag_t t2, logic use_imm);
        dispatch_t d;
        d.op         = op;
        d.ctx        = ctx;
        d.dest       = tag_t'($random(seed));
        d.src1_ready = r1;
        d.src1_tag   = t1;
        d.src1_val   = $random(seed);
        d.src2_ready = r2;
        d.src2_tag   = t2;
        d.src2_val   = $random(seed);
        d.use_imm    = use_imm;
        d.imm        = $random(seed);
        return d;
    endfunction

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic dispatch_one(input dispatch_t d);
        logic taken;
        dispatch_valid = 1'b1;
        dispatch_info  = d;
        taken          = 1'b0;
        while (!taken) begin
            taken = dispatch_ready;
            @(negedge clk);
        end
        dispatch_valid = 1'b0;
    endtask

    task automatic broadcast(input tag_t tag);
        result_valid = 1'b1;
        result.tag   = tag;
        result.value = $random(seed);
        @(negedge clk);
        result_valid = 1'b0;
    endtask

    task automatic flush(input ctx_t mask);
        branch_hazard = 1'b1;
        hazard_ctx    = mask;
        @(negedge clk);
        branch_hazard = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic drain();
        while (u_checks.model_count != 0 || exec_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic start_test(input string name);
        u_checks.test_name = name;
        errs_before        = u_checks.err_count;
    endtask

    task automatic end_test();
        int errs;
        errs = u_checks.err_count - errs_before;
        tests_run++;
        if (errs == 0) begin
            $display("test %s passed", u_checks.test_name);
        end else begin
            $display("test %s failed with %0d errors", u_checks.test_name, errs);
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_info  = '0;
        result_valid   = 1'b0;
        result         = '0;
        branch_hazard  = 1'b0;
        hazard_ctx     = '0;

        start_test("reset");
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        idle(3);
        end_test();

        // odd ones take source 2 from the immediate
        start_test("ready_dispatch");
        jitter = 1'b1;
        for (int i = 0; i < 6; i++) begin
            dispatch_one(make_inst(op_t'(i), ctx_t'(1 << (i % 4)), 1'b1, 6'd0,
                                   (i % 2) == 0, 6'd0, (i % 2) == 1));
        end
        drain();
        end_test();

        start_test("wakeup");
        dispatch_one(make_inst(4'h1, 4'b0001, 1'b0, 6'd40, 1'b1, 6'd0, 1'b0));
        dispatch_one(make_inst(4'h2, 4'b0010, 1'b1, 6'd0, 1'b1, 6'd0, 1'b0));
        dispatch_one(make_inst(4'h3, 4'b0100, 1'b1, 6'd0, 1'b0, 6'd41, 1'b0));
        idle(4);
        broadcast(6'd41);
        idle(2);
        // result lands on the same edge as the dispatch waiting for it
        result_valid = 1'b1;
        result.tag   = 6'd42;
        result.value = $random(seed);
        dispatch_one(make_inst(4'h4, 4'b1000, 1'b0, 6'd42, 1'b1, 6'd0, 1'b0));
        result_valid = 1'b0;
        broadcast(6'd40);
        drain();
        end_test();

        // four waiting entries fill the issue range, a ready one sits behind them
        start_test("issue_range");
        for (int i = 0; i < `IW_ISSUE_RANGE; i++) begin
            dispatch_one(make_inst(op_t'(i + 8), 4'b0001, 1'b0, tag_t'(50 + i),
                                   1'b1, 6'd0, 1'b0));
        end
        dispatch_one(make_inst(4'hc, 4'b0010, 1'b1, 6'd0, 1'b1, 6'd0, 1'b0));
        idle(6);
        for (int i = 0; i < `IW_ISSUE_RANGE; i++) begin
            broadcast(tag_t'(50 + i));
            idle(2);
        end
        drain();
        end_test();

        start_test("backpressure_full");
        jitter = 1'b0;
        stall  = 1'b1;
        for (int i = 0; i < `IW_DEPTH; i++) begin
            dispatch_one(make_inst(op_t'(i), 4'b0001, 1'b1, 6'd0, 1'b1, 6'd0, 1'b0));
        end
        idle(5);
        stall = 1'b0;
        // waits on a full window until the first issue frees a slot
        dispatch_one(make_inst(4'hf, 4'b0010, 1'b1, 6'd0, 1'b1, 6'd0, 1'b0));
        drain();
        end_test();

        // entries 2 and 5 wait on tag 60, mask 0011 kills 1, 4 and 5
        start_test("hazard_flush");
        stall = 1'b1;
        for (int i = 0; i < 6; i++) begin
            dispatch_one(make_inst(op_t'(i), ctx_t'(1 << (i % 4)), 1'b1, 6'd0,
                                   !(i == 2 || i == 5), 6'd60, 1'b0));
        end
        idle(2);
        // oldest entry issues on the hazard edge
        stall = 1'b0;
        flush(4'b0011);
        broadcast(6'd60);
        drain();
        idle(4);
        end_test();

        $display("tests %0d, issues %0d, errors %0d", tests_run, u_checks.issue_count,
                 u_checks.err_count);
        if (u_checks.err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+verilog
verilog/iw_pkg.sv
verilog/window_compact.sv
verilog/issue_select.sv
verilog/window_entries.sv
verilog/inst_window.sv
testbench/tb_iw_checks.sv
testbench/tb_inst_window.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_inst_window \
    -f project.f --Mdir obj_dir -o tb_inst_window || exit 1
out=$(./obj_dir/tb_inst_window)
echo "$out"
echo "$out" | grep -qx "No errors" && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}
